//--- list.f
+incdir+verilog
verilog/card_pkg.sv
verilog/square_raster.sv
verilog/card_painter.sv
verilog/game_fsm.sv
verilog/card_game_top.sv
dv/tb_clock.sv
dv/card_game_checker.sv
dv/card_game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the memory card game testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module card_game_tb \
	-f list.f -o card_game_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/card_game_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
	exit 0
fi
exit 1

//--- dv/card_game_tb.sv
`include "card_params.svh"

module card_game_tb
	import card_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT   = 5000;
	localparam int FRAME_PIX = 4 * (`CARD_FRAME_SIZE - 1);
	localparam int TILE_PIX  = `CARD_TILE_SIZE * `CARD_TILE_SIZE;

	logic                      clk;
	logic                      resetn;
	logic                      start;
	logic                      left;
	logic                      right;
	logic                      select;
	logic [`CARD_X_W-1:0]      x;
	logic [`CARD_Y_W-1:0]      y;
	logic [`CARD_COLOUR_W-1:0] colour;
	logic                      plot;
	int                        tests_run;
	int                        tests_failed;
	int                        test_errors;
	int                        waited;

	tb_clock clock_gen (.clk(clk), .resetn(resetn));

	card_game_top uut
	(
		.clk(clk), .resetn(resetn), .start(start), .left(left), .right(right),
		.select(select), .x(x), .y(y), .colour(colour), .plot(plot)
	);

	function automatic logic [2:0] want_colour(input draw_op_e op, input logic [3:0] grid);
		case (op)
			DRAW_FRAME:   return `COLOUR_FRAME;
			DRAW_UNFRAME: return `COLOUR_UNFRAME;
			DRAW_CARD:    return 3'(int'(grid) % 8);  // Fixed deal
			default:      return `COLOUR_BLANK;
		endcase
	endfunction

	function automatic logic in_place(input draw_op_e op, input logic [3:0] grid);
		logic framed;
		int   side;
		int   dx;
		int   dy;
		framed = (op == DRAW_FRAME) || (op == DRAW_UNFRAME);
		side   = framed ? `CARD_FRAME_SIZE : `CARD_TILE_SIZE;
		dx     = int'(x) - (framed ? `CARD_FRAME_X0 : `CARD_TILE_X0) - (int'(grid) % 4) * `CARD_PITCH;
		dy     = int'(y) - (framed ? `CARD_FRAME_Y0 : `CARD_TILE_Y0) - (int'(grid) / 4) * `CARD_PITCH;
		if (dx < 0 || dy < 0 || dx >= side || dy >= side)
			return 1'b0;
		if (framed)
			return (dx == 0) || (dy == 0) || (dx == side - 1) || (dy == side - 1);
		return 1'b1;
	endfunction

	// Keys in the order start, left, right, select
	task automatic tap_keys(input logic [3:0] keys);
		@(posedge clk);
		#2;
		{start, left, right, select} = keys;
		repeat (2) @(posedge clk);
		#2;
		{start, left, right, select} = 4'b0000;
	endtask

	task automatic expect_op(input draw_op_e op, input logic [3:0] grid, input int n);
		int seen;
		int cycles;
		int bad;
		bit written [logic [16:0]];
		seen   = 0;
		cycles = 0;
		bad    = 0;
		while (seen < n && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
			if (plot)
			begin
				seen++;
				if (bad == 0 && !in_place(op, grid))
					$display("ERR x/y: 0x%h/0x%h outside square of grid 0x%h", x, y, grid);
				else if (bad == 0 && colour != want_colour(op, grid))
					$display("ERR colour: expected 0x%h got 0x%h", want_colour(op, grid), colour);
				else if (bad == 0 && written.exists({x, y}))
					$display("ERR x/y: 0x%h/0x%h written twice", x, y);
				if (!in_place(op, grid) || colour != want_colour(op, grid) ||
					written.exists({x, y}))
					bad++;
				written[{x, y}] = 1'b1;
			end
		end
		if (seen < n)
			$display("Timed out waiting for pixel writes, %0d of %0d arrived", seen, n);
		if (seen < n || bad != 0)
			test_errors++;
	endtask

	task automatic move(input logic [3:0] keys, input logic [3:0] from, input logic [3:0] to);
		tap_keys(keys);
		expect_op(DRAW_UNFRAME, from, FRAME_PIX);
		expect_op(DRAW_FRAME, to, FRAME_PIX);
	endtask

	task automatic finish_test(input string name, input int total);
		int extra;
		extra = 0;
		repeat (8)
		begin
			@(negedge clk);
			if (plot)
				extra++;
		end
		if (extra != 0)
		begin
			$display("ERR plot count: expected 0x%h got 0x%h", total, total + extra);
			test_errors++;
		end
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("%-12s %s", name, (test_errors == 0) ? "ok" : "failed");
		test_errors = 0;
	endtask

	initial
	begin
		{start, left, right, select} = 4'b0000;
		tests_run    = 0;
		tests_failed = 0;
		test_errors  = 0;
		waited       = 0;

		while (resetn !== 1'b1 && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (resetn !== 1'b1)
		begin
			$display("Reset never released");
			test_errors++;
		end
		repeat (20) @(negedge clk);  // Idle with start low
		finish_test("reset", 0);

		tap_keys(4'b1000);
		expect_op(DRAW_FRAME, 4'd0, FRAME_PIX);
		finish_test("start", FRAME_PIX);

		move(4'b0100, 4'd0, 4'd15);
		move(4'b0010, 4'd15, 4'd0);
		finish_test("wrap", 4 * FRAME_PIX);

		move(4'b0010, 4'd0, 4'd1);
		finish_test("right", 2 * FRAME_PIX);

		tap_keys(4'b0001);
		expect_op(DRAW_CARD, 4'd1, TILE_PIX);
		finish_test("first_pick", TILE_PIX);

		for (int g = 1; g < 9; g++)
			move(4'b0010, 4'(g), 4'(g + 1));
		tap_keys(4'b0001);
		expect_op(DRAW_CARD, 4'd9, TILE_PIX);
		finish_test("match", 16 * FRAME_PIX + TILE_PIX);

		move(4'b0010, 4'd9, 4'd10);
		tap_keys(4'b0001);
		expect_op(DRAW_CARD, 4'd10, TILE_PIX);
		move(4'b0100, 4'd10, 4'd9);
		tap_keys(4'b0001);
		expect_op(DRAW_BLANK, 4'd10, TILE_PIX);  // Second card stays untouched
		finish_test("mismatch", 4 * FRAME_PIX + 2 * TILE_PIX);

		$display("Tests run %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, uut.chk.fail_count);
		if (tests_failed == 0 && uut.chk.fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- dv/card_game_checker.sv
`include "card_params.svh"

module card_game_checker
	import card_pkg::*;
(
	input logic                      clk,
	input logic                      resetn,
	input logic                      plot,
	input logic [`CARD_X_W-1:0]      x,
	input logic [`CARD_Y_W-1:0]      y,
	input logic [`CARD_COLOUR_W-1:0] colour,
	input draw_op_e                  draw_op,
	input logic [3:0]                draw_grid
);

	timeunit 1ns;
	timeprecision 100ps;

	int         fail_count = 0;
	draw_op_e   op_q;
	logic [3:0] grid_q;
	logic       framed;
	int         side;
	int         dx;
	int         dy;
	logic       in_square;
	logic       on_border;
	logic [2:0] want;

	// Pixel leaves one cycle after its operation was presented
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			op_q   <= DRAW_NONE;
			grid_q <= '0;
		end
		else
		begin
			op_q   <= draw_op;
			grid_q <= draw_grid;
		end
	end

	always_comb
	begin
		framed    = (op_q == DRAW_FRAME) || (op_q == DRAW_UNFRAME);
		side      = framed ? `CARD_FRAME_SIZE : `CARD_TILE_SIZE;
		dx        = int'(x) - (framed ? `CARD_FRAME_X0 : `CARD_TILE_X0)
			- (int'(grid_q) % 4) * `CARD_PITCH;
		dy        = int'(y) - (framed ? `CARD_FRAME_Y0 : `CARD_TILE_Y0)
			- (int'(grid_q) / 4) * `CARD_PITCH;
		in_square = (dx >= 0) && (dy >= 0) && (dx < side) && (dy < side);
		on_border = (dx == 0) || (dy == 0) || (dx == side - 1) || (dy == side - 1);
		case (op_q)
			DRAW_FRAME:   want = 3'd1;
			DRAW_UNFRAME: want = 3'd7;
			DRAW_CARD:    want = 3'(int'(grid_q) % 8);
			default:      want = 3'd0;
		endcase
	end

	reset_quiet: assert property (@(posedge clk) !resetn |-> !plot)
		else begin $error("plot high during reset"); fail_count++; end

	no_stray_write: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (op_q != DRAW_NONE))
		else begin $error("pixel write with no draw operation"); fail_count++; end

	inside_square: assert property (@(posedge clk) disable iff (!resetn) plot |-> in_square)
		else begin $error("pixel write outside its square"); fail_count++; end

	frame_border: assert property (@(posedge clk) disable iff (!resetn)
		(plot && framed) |-> on_border)
		else begin $error("frame pixel off the border"); fail_count++; end

	pixel_colour: assert property (@(posedge clk) disable iff (!resetn) plot |-> (colour == want))
		else begin $error("wrong pixel colour"); fail_count++; end

endmodule

bind card_game_top card_game_checker chk
(
	.clk       (clk),
	.resetn    (resetn),
	.plot      (plot),
	.x         (x),
	.y         (y),
	.colour    (colour),
	.draw_op   (draw_op),
	.draw_grid (draw_grid)
);

//--- dv/tb_clock.sv
module tb_clock
(
	output logic clk,
	output logic resetn
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	initial
	begin
		resetn = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		resetn = 1'b1;
	end

endmodule

//--- verilog/card_game_top.sv
`include "card_params.svh"

module card_game_top
	import card_pkg::*;
(
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      start,
	input  logic                      left,
	input  logic                      right,
	input  logic                      select,
	output logic [`CARD_X_W-1:0]      x,
	output logic [`CARD_Y_W-1:0]      y,
	output logic [`CARD_COLOUR_W-1:0] colour,
	output logic                      plot
);

	draw_op_e   draw_op;
	logic [3:0] draw_grid;
	logic       draw_done;

	game_fsm u_game_fsm
	(
		.clk       (clk),
		.resetn    (resetn),
		.start     (start),
		.left      (left),
		.right     (right),
		.select    (select),
		.draw_done (draw_done),
		.draw_op   (draw_op),
		.draw_grid (draw_grid)
	);

	card_painter u_card_painter
	(
		.clk       (clk),
		.resetn    (resetn),
		.draw_op   (draw_op),
		.draw_grid (draw_grid),
		.draw_done (draw_done),
		.x         (x),
		.y         (y),
		.colour    (colour),
		.plot      (plot)
	);

endmodule

//--- verilog/game_fsm.sv
`include "card_params.svh"

module game_fsm
	import card_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       start,
	input  logic       left,
	input  logic       right,
	input  logic       select,
	input  logic       draw_done,
	output draw_op_e   draw_op,
	output logic [3:0] draw_grid
);

	localparam logic [3:0] LAST_GRID = 4'(`CARD_COUNT - 1);

	game_state_e state;
	game_state_e state_next;
	logic [3:0]  cursor;
	logic [3:0]  prev_cursor;
	logic [3:0]  first_pick;
	logic        picked;
	logic        move_left;
	logic        move_right;
	logic        pick_first;
	logic        is_match;

	// Keys act on release
	assign move_left  = (state == S_LEFT_WAIT) && !left;
	assign move_right = (state == S_RIGHT_WAIT) && !right;
	assign pick_first = (state == S_SELECT_WAIT) && !select && !picked;
	assign is_match   = (card_image(first_pick) == card_image(cursor));

	always_comb
	begin
		state_next = state;
		case (state)
			S_IDLE:
				if (start)
					state_next = S_DRAW_FIRST;
			S_KEY_WAIT:
				if (left)
					state_next = S_LEFT_WAIT;
				else if (right)
					state_next = S_RIGHT_WAIT;
				else if (select)
					state_next = S_SELECT_WAIT;
			S_LEFT_WAIT:
				if (!left)
					state_next = S_ERASE_FRAME;
			S_RIGHT_WAIT:
				if (!right)
					state_next = S_ERASE_FRAME;
			S_SELECT_WAIT:
				if (!select)
					state_next = picked ? S_COMPARE : S_SHOW_FIRST;
			S_ERASE_FRAME:
				if (draw_done)
					state_next = S_DRAW_FRAME;
			S_DRAW_FIRST, S_DRAW_FRAME, S_SHOW_FIRST, S_SHOW_SECOND, S_HIDE_FIRST:
				if (draw_done)
					state_next = S_KEY_WAIT;
			S_COMPARE:
				state_next = is_match ? S_SHOW_SECOND : S_HIDE_FIRST;
			default:
				state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state       <= S_IDLE;
			cursor      <= 4'd0;
			prev_cursor <= 4'd0;
			picked      <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (move_left || move_right)
				prev_cursor <= cursor;  // Old spot gets unframed
			if (move_left)
				cursor <= (cursor == 4'd0) ? LAST_GRID : cursor - 4'd1;
			else if (move_right)
				cursor <= (cursor == LAST_GRID) ? 4'd0 : cursor + 4'd1;
			if (pick_first)
				picked <= 1'b1;
			else if (state == S_COMPARE)
				picked <= 1'b0;  // Pair resolved either way
		end
	end

	always_ff @(posedge clk)
	begin
		if (pick_first)
			first_pick <= cursor;
	end

	always_comb
	begin
		draw_op   = DRAW_NONE;
		draw_grid = cursor;
		case (state)
			S_DRAW_FIRST, S_DRAW_FRAME:
				draw_op = DRAW_FRAME;
			S_ERASE_FRAME:
			begin
				draw_op   = DRAW_UNFRAME;
				draw_grid = prev_cursor;
			end
			S_SHOW_FIRST, S_SHOW_SECOND:
				draw_op = DRAW_CARD;
			S_HIDE_FIRST:
			begin
				draw_op   = DRAW_BLANK;
				draw_grid = first_pick;  // Mismatch turns first card black
			end
			default:
				draw_op = DRAW_NONE;
		endcase
	end

endmodule

//--- verilog/card_painter.sv
`include "card_params.svh"

module card_painter
	import card_pkg::*;
(
	input  logic                      clk,
	input  logic                      resetn,
	input  draw_op_e                  draw_op,
	input  logic [3:0]                draw_grid,
	output logic                      draw_done,
	output logic [`CARD_X_W-1:0]      x,
	output logic [`CARD_Y_W-1:0]      y,
	output logic [`CARD_COLOUR_W-1:0] colour,
	output logic                      plot
);

	logic                      frame_run;
	logic                      tile_run;
	logic [5:0]                f_col, f_row, t_col, t_row;
	logic                      f_last, t_last;
	logic [5:0]                col_off, row_off;
	logic [1:0]                grid_col, grid_row;
	logic [`CARD_X_W-1:0]      base_x, pix_x;
	logic [`CARD_Y_W-1:0]      base_y, pix_y;
	logic                      border;
	logic                      pix_plot;
	logic [`CARD_COLOUR_W-1:0] pix_colour;

	assign frame_run = (draw_op == DRAW_FRAME) || (draw_op == DRAW_UNFRAME);
	assign tile_run  = (draw_op == DRAW_CARD) || (draw_op == DRAW_BLANK);

	square_raster #(.SIDE(`CARD_FRAME_SIZE)) frame_raster
	(
		.clk(clk), .resetn(resetn), .run(frame_run),
		.col_off(f_col), .row_off(f_row), .last(f_last)
	);

	square_raster #(.SIDE(`CARD_TILE_SIZE)) tile_raster
	(
		.clk(clk), .resetn(resetn), .run(tile_run),
		.col_off(t_col), .row_off(t_row), .last(t_last)
	);

	assign draw_done = f_last | t_last;

	assign grid_col = 2'(draw_grid % `CARD_GRID_DIM);
	assign grid_row = 2'(draw_grid / `CARD_GRID_DIM);
	assign base_x   = frame_run ? `CARD_X_W'(`CARD_FRAME_X0) : `CARD_X_W'(`CARD_TILE_X0);
	assign base_y   = frame_run ? `CARD_Y_W'(`CARD_FRAME_Y0) : `CARD_Y_W'(`CARD_TILE_Y0);
	assign col_off  = frame_run ? f_col : t_col;
	assign row_off  = frame_run ? f_row : t_row;

	// Column offset moves x, row offset moves y
	assign pix_x = base_x + `CARD_X_W'(grid_col * `CARD_PITCH) + `CARD_X_W'(col_off);
	assign pix_y = base_y + `CARD_Y_W'(grid_row * `CARD_PITCH) + `CARD_Y_W'(row_off);

	assign border = (f_col == 6'd0) || (f_col == 6'(`CARD_FRAME_SIZE - 1)) ||
		(f_row == 6'd0) || (f_row == 6'(`CARD_FRAME_SIZE - 1));

	always_comb
	begin
		pix_plot   = 1'b0;
		pix_colour = `COLOUR_BLANK;
		case (draw_op)
			DRAW_FRAME:
			begin
				pix_plot   = border;
				pix_colour = `COLOUR_FRAME;
			end
			DRAW_UNFRAME:
			begin
				pix_plot   = border;
				pix_colour = `COLOUR_UNFRAME;
			end
			DRAW_CARD:
			begin
				pix_plot   = 1'b1;
				pix_colour = card_image(draw_grid);  // Solid face colour
			end
			DRAW_BLANK:
				pix_plot = 1'b1;
			default:
				pix_plot = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			plot <= 1'b0;
		else
			plot <= pix_plot;
	end

	always_ff @(posedge clk)
	begin
		x      <= pix_x;
		y      <= pix_y;
		colour <= pix_colour;
	end

endmodule

//--- verilog/square_raster.sv
module square_raster
#(
	parameter int SIDE = 43
)
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       run,
	output logic [5:0] col_off,
	output logic [5:0] row_off,
	output logic       last
);

	localparam int COUNT_MAX = SIDE * SIDE - 1;
	localparam int COUNT_W   = $clog2(SIDE * SIDE);

	logic [COUNT_W-1:0] count;

	// Wraps on last so a back-to-back run starts at zero
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			count <= '0;
		else if (!run || last)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	assign last    = (count == COUNT_W'(COUNT_MAX));
	assign col_off = 6'(count / SIDE);
	assign row_off = 6'(count % SIDE);

endmodule

//--- verilog/card_pkg.sv
package card_pkg;

	typedef enum logic [3:0] {
		S_IDLE,
		S_DRAW_FIRST,
		S_KEY_WAIT,
		S_LEFT_WAIT,
		S_RIGHT_WAIT,
		S_SELECT_WAIT,
		S_ERASE_FRAME,
		S_DRAW_FRAME,
		S_SHOW_FIRST,
		S_COMPARE,
		S_SHOW_SECOND,
		S_HIDE_FIRST
	} game_state_e;

	typedef enum logic [2:0] {
		DRAW_NONE,
		DRAW_FRAME,
		DRAW_UNFRAME,
		DRAW_CARD,
		DRAW_BLANK
	} draw_op_e;

	// Fixed deal where cards g and g+8 share an image
	function automatic logic [2:0] card_image(input logic [3:0] grid);
		return grid[2:0];
	endfunction

endpackage

//--- verilog/card_params.svh
`ifndef CARD_PARAMS_SVH
`define CARD_PARAMS_SVH

// Grid of cards
`define CARD_GRID_DIM    4
`define CARD_COUNT       16

// Square sides and grid spacing in pixels
`define CARD_FRAME_SIZE  43
`define CARD_TILE_SIZE   35
`define CARD_PITCH       39

`define CARD_FRAME_X0    80
`define CARD_FRAME_Y0    40
`define CARD_TILE_X0     84
`define CARD_TILE_Y0     44

`define CARD_X_W         9
`define CARD_Y_W         8
`define CARD_COLOUR_W    3

`define COLOUR_FRAME     3'd1  // Blue
`define COLOUR_UNFRAME   3'd7  // White
`define COLOUR_BLANK     3'd0  // Black

`endif
